/* bus_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cache_config.svh"

module bus_arbiter (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_data_request,
	input wire cache_pkg::bus_req_t i_data_req,
	output logic o_data_ready,
	input wire logic i_fetch_request,
	input wire cache_pkg::bus_req_t i_fetch_req,
	output logic o_fetch_ready,
	output logic [`CACHE_ADDR_BITS-1:0] o_rdata,
	output logic o_bus_request,
	output cache_pkg::bus_req_t o_bus_req,
	input wire logic i_bus_ready,
	input wire logic [`CACHE_ADDR_BITS-1:0] i_bus_rdata
);
	import cache_pkg::*;

	logic locked;
	bus_owner_t owner;
	bus_owner_t last_owner;
	bus_owner_t grant;

	// Round robin between the two caches when both ask.
	always_comb begin
		if (locked) begin
			grant = owner;
		end else if (i_data_request && i_fetch_request) begin
			grant = (last_owner == OWNER_DATA) ? OWNER_FETCH : OWNER_DATA;
		end else if (i_fetch_request) begin
			grant = OWNER_FETCH;
		end else begin
			grant = OWNER_DATA;
		end
	end

	assign o_bus_request = (grant == OWNER_DATA) ? i_data_request : i_fetch_request;
	assign o_bus_req = (grant == OWNER_DATA) ? i_data_req : i_fetch_req;
	assign o_data_ready = i_bus_ready && o_bus_request && (grant == OWNER_DATA);
	assign o_fetch_ready = i_bus_ready && o_bus_request && (grant == OWNER_FETCH);
	assign o_rdata = i_bus_rdata;

	// Lock holds the grant until the transfer completes.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			locked <= 1'b0;
			owner <= OWNER_DATA;
			last_owner <= OWNER_FETCH;
		end else if (o_bus_request && !i_bus_ready) begin
			locked <= 1'b1;
			owner <= grant;
		end else if (o_bus_request) begin
			locked <= 1'b0;
			last_owner <= grant;
		end
	end

endmodule

`default_nettype wire

/* cache_bram.sv */
`default_nettype none
`timescale 1ns/1ps

module cache_bram #(
	parameter type entry_t = logic [31:0],
	parameter int DEPTH = 16
) (
	input wire logic i_clock,
	input wire logic i_write,
	input wire logic [$clog2(DEPTH)-1:0] i_address,
	input wire entry_t i_wdata,
	output entry_t o_rdata
);

	entry_t mem [DEPTH];

	// Read returns the old contents when written in the same cycle.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_address] <= i_wdata;
		end
		o_rdata <= mem[i_address];
	end

endmodule

`default_nettype wire

/* cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Address and data width of the processor.
`define CACHE_ADDR_BITS 32

// Index bits per cache, 16 entries each.
`define CACHE_INDEX_BITS 4

// Entries per cache.
`define CACHE_ENTRIES (1 << `CACHE_INDEX_BITS)

// Tag written into every entry by the sweep.
`define CACHE_INVALID_TAG {(`CACHE_ADDR_BITS - 2){1'b1}}

`endif

/* cache_pkg.sv */
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

	// CPU side request, held steady until ready.
	typedef struct packed {
		logic rw;
		logic flush;
		logic cacheable;
		logic [`CACHE_ADDR_BITS-1:0] address;
		logic [`CACHE_ADDR_BITS-1:0] wdata;
	} cpu_req_t;

	// Memory bus request.
	typedef struct packed {
		logic rw;
		logic [`CACHE_ADDR_BITS-1:0] address;
		logic [`CACHE_ADDR_BITS-1:0] wdata;
	} bus_req_t;

	// Tag is the word address of the cached word.
	typedef struct packed {
		logic [`CACHE_ADDR_BITS-1:0] data;
		logic [`CACHE_ADDR_BITS-3:0] tag;
		logic dirty;
		logic valid;
	} dcache_entry_t;

	typedef struct packed {
		logic [`CACHE_ADDR_BITS-1:0] data;
		logic [`CACHE_ADDR_BITS-3:0] tag;
		logic valid;
	} icache_entry_t;

	typedef enum logic {
		OWNER_DATA = 1'b0,
		OWNER_FETCH = 1'b1
	} bus_owner_t;

endpackage

`default_nettype wire

/* cache_subsystem.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cache_config.svh"

module cache_subsystem (
	input wire logic i_clock,
	input wire logic i_reset,

	// CPU data port.
	input wire logic i_data_request,
	input wire cache_pkg::cpu_req_t i_data_req,
	output logic o_data_ready,
	output logic [`CACHE_ADDR_BITS-1:0] o_data_rdata,

	// CPU fetch port.
	input wire logic i_fetch_request,
	input wire cache_pkg::cpu_req_t i_fetch_req,
	output logic o_fetch_ready,
	output logic [`CACHE_ADDR_BITS-1:0] o_fetch_rdata,

	// Memory bus.
	output logic o_bus_request,
	output cache_pkg::bus_req_t o_bus_req,
	input wire logic i_bus_ready,
	input wire logic [`CACHE_ADDR_BITS-1:0] i_bus_rdata
);
	import cache_pkg::*;

	logic data_bus_request;
	bus_req_t data_bus_req;
	logic data_bus_ready;
	logic fetch_bus_request;
	bus_req_t fetch_bus_req;
	logic fetch_bus_ready;
	logic [`CACHE_ADDR_BITS-1:0] arb_rdata;

	data_cache u_data_cache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_data_request),
		.i_req(i_data_req),
		.o_ready(o_data_ready),
		.o_rdata(o_data_rdata),
		.o_bus_request(data_bus_request),
		.o_bus_req(data_bus_req),
		.i_bus_ready(data_bus_ready),
		.i_bus_rdata(arb_rdata)
	);

	instruction_cache u_instruction_cache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_fetch_request),
		.i_req(i_fetch_req),
		.o_ready(o_fetch_ready),
		.o_rdata(o_fetch_rdata),
		.o_bus_request(fetch_bus_request),
		.o_bus_req(fetch_bus_req),
		.i_bus_ready(fetch_bus_ready),
		.i_bus_rdata(arb_rdata)
	);

	bus_arbiter u_bus_arbiter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data_request(data_bus_request),
		.i_data_req(data_bus_req),
		.o_data_ready(data_bus_ready),
		.i_fetch_request(fetch_bus_request),
		.i_fetch_req(fetch_bus_req),
		.o_fetch_ready(fetch_bus_ready),
		.o_rdata(arb_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_req(o_bus_req),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

`default_nettype wire

/* data_cache.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cache_config.svh"

module data_cache (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_request,
	input wire cache_pkg::cpu_req_t i_req,
	output logic o_ready,
	output logic [`CACHE_ADDR_BITS-1:0] o_rdata,
	output logic o_bus_request,
	output cache_pkg::bus_req_t o_bus_req,
	input wire logic i_bus_ready,
	input wire logic [`CACHE_ADDR_BITS-1:0] i_bus_rdata
);
	import cache_pkg::*;

	typedef enum logic [3:0] {
		ST_SWEEP,
		ST_IDLE,
		ST_FLUSH_SETUP,
		ST_FLUSH_CHECK,
		ST_FLUSH_WRITE,
		ST_PASS,
		ST_WRITE_SETUP,
		ST_WRITE_WAIT,
		ST_READ_SETUP,
		ST_WB_WAIT,
		ST_FILL_WAIT
	} state_t;

	state_t state;
	state_t next_state;
	logic [`CACHE_INDEX_BITS:0] walk_index;
	logic [`CACHE_INDEX_BITS:0] next_walk_index;
	logic walk_done;

	logic ram_write;
	logic [`CACHE_INDEX_BITS-1:0] ram_address;
	dcache_entry_t ram_wdata;
	dcache_entry_t ram_rdata;

	logic [`CACHE_INDEX_BITS-1:0] req_index;
	logic [`CACHE_ADDR_BITS-3:0] req_tag;
	logic tag_match;

	dcache_entry_t write_entry;
	dcache_entry_t fill_entry;
	dcache_entry_t clean_entry;
	dcache_entry_t invalid_entry;
	bus_req_t victim_req;
	bus_req_t fill_req;
	bus_req_t pass_req;

	// The RAM address follows the request, so the entry is ready one cycle later.
	cache_bram #(
		.entry_t(dcache_entry_t),
		.DEPTH(`CACHE_ENTRIES)
	) u_ram (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	assign req_index = i_req.address[`CACHE_INDEX_BITS+1:2];
	assign req_tag = i_req.address[`CACHE_ADDR_BITS-1:2];
	assign tag_match = (ram_rdata.tag == req_tag);
	assign walk_done = walk_index[`CACHE_INDEX_BITS];

	// Entry images and bus requests.
	always_comb begin
		write_entry = '{data: i_req.wdata, tag: req_tag, dirty: 1'b1, valid: 1'b1};
		fill_entry = '{data: i_bus_rdata, tag: req_tag, dirty: 1'b0, valid: 1'b1};
		clean_entry = ram_rdata;
		clean_entry.dirty = 1'b0;
		invalid_entry = '{data: '0, tag: `CACHE_INVALID_TAG, dirty: 1'b0, valid: 1'b0};
		victim_req = '{rw: 1'b1, address: {ram_rdata.tag, 2'b00}, wdata: ram_rdata.data};
		fill_req = '{rw: 1'b0, address: i_req.address, wdata: '0};
		pass_req = '{rw: i_req.rw, address: i_req.address, wdata: i_req.wdata};
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_SWEEP;
			walk_index <= '0;
		end else begin
			state <= next_state;
			walk_index <= next_walk_index;
		end
	end

	always_comb begin
		next_state = state;
		next_walk_index = walk_index;
		o_ready = 1'b0;
		o_rdata = ram_rdata.data;
		o_bus_request = 1'b0;
		o_bus_req = fill_req;
		ram_write = 1'b0;
		ram_address = req_index;
		ram_wdata = write_entry;

		case (state)
			// Invalidate every entry after reset.
			ST_SWEEP: begin
				ram_address = walk_index[`CACHE_INDEX_BITS-1:0];
				ram_wdata = invalid_entry;
				if (!walk_done) begin
					ram_write = 1'b1;
					next_walk_index = walk_index + 1'b1;
				end else begin
					next_walk_index = '0;
					next_state = ST_IDLE;
				end
			end

			ST_IDLE: begin
				if (i_request) begin
					if (i_req.flush) begin
						next_walk_index = '0;
						next_state = ST_FLUSH_SETUP;
					end else if (!i_req.cacheable) begin
						next_state = ST_PASS;
					end else if (i_req.rw) begin
						next_state = ST_WRITE_SETUP;
					end else begin
						next_state = ST_READ_SETUP;
					end
				end
			end

			// ============================================================
			// Flush
			// ============================================================
			ST_FLUSH_SETUP: begin
				ram_address = walk_index[`CACHE_INDEX_BITS-1:0];
				if (walk_done) begin
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end else begin
					next_state = ST_FLUSH_CHECK;
				end
			end

			ST_FLUSH_CHECK: begin
				ram_address = walk_index[`CACHE_INDEX_BITS-1:0];
				if (ram_rdata.dirty) begin
					next_state = ST_FLUSH_WRITE;
				end else begin
					next_walk_index = walk_index + 1'b1;
					next_state = ST_FLUSH_SETUP;
				end
			end

			// Entry stays valid, now clean.
			ST_FLUSH_WRITE: begin
				ram_address = walk_index[`CACHE_INDEX_BITS-1:0];
				ram_wdata = clean_entry;
				o_bus_request = 1'b1;
				o_bus_req = victim_req;
				if (i_bus_ready) begin
					ram_write = 1'b1;
					next_walk_index = walk_index + 1'b1;
					next_state = ST_FLUSH_SETUP;
				end
			end

			// Uncached access goes straight to the bus.
			ST_PASS: begin
				o_bus_request = 1'b1;
				o_bus_req = pass_req;
				o_rdata = i_bus_rdata;
				o_ready = i_bus_ready;
				if (i_bus_ready) begin
					next_state = ST_IDLE;
				end
			end

			// ============================================================
			// Write
			// ============================================================
			ST_WRITE_SETUP: begin
				if (ram_rdata.dirty && !tag_match) begin
					next_state = ST_WRITE_WAIT;
				end else begin
					ram_write = 1'b1;
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end
			end

			// Victim write-back, then store the new word.
			ST_WRITE_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_req = victim_req;
				if (i_bus_ready) begin
					ram_write = 1'b1;
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end
			end

			// ============================================================
			// Read
			// ============================================================
			ST_READ_SETUP: begin
				if (ram_rdata.valid && tag_match) begin
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end else if (ram_rdata.dirty) begin
					next_state = ST_WB_WAIT;
				end else begin
					next_state = ST_FILL_WAIT;
				end
			end

			ST_WB_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_req = victim_req;
				if (i_bus_ready) begin
					next_state = ST_FILL_WAIT;
				end
			end

			ST_FILL_WAIT: begin
				o_bus_request = 1'b1;
				o_rdata = i_bus_rdata;
				ram_wdata = fill_entry;
				if (i_bus_ready) begin
					ram_write = 1'b1;
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end
			end

			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* instruction_cache.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cache_config.svh"

module instruction_cache (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_request,
	input wire cache_pkg::cpu_req_t i_req,
	output logic o_ready,
	output logic [`CACHE_ADDR_BITS-1:0] o_rdata,
	output logic o_bus_request,
	output cache_pkg::bus_req_t o_bus_req,
	input wire logic i_bus_ready,
	input wire logic [`CACHE_ADDR_BITS-1:0] i_bus_rdata
);
	import cache_pkg::*;

	typedef enum logic [1:0] {
		ST_SWEEP,
		ST_IDLE,
		ST_LOOKUP,
		ST_FILL_WAIT
	} state_t;

	state_t state;
	state_t next_state;
	logic [`CACHE_INDEX_BITS:0] walk_index;
	logic [`CACHE_INDEX_BITS:0] next_walk_index;

	logic ram_write;
	logic [`CACHE_INDEX_BITS-1:0] ram_address;
	icache_entry_t ram_wdata;
	icache_entry_t ram_rdata;
	logic [`CACHE_ADDR_BITS-3:0] req_tag;

	cache_bram #(
		.entry_t(icache_entry_t),
		.DEPTH(`CACHE_ENTRIES)
	) u_ram (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	assign req_tag = i_req.address[`CACHE_ADDR_BITS-1:2];

	// Always a read of the fetch address.
	assign o_bus_req = '{rw: 1'b0, address: i_req.address, wdata: '0};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_SWEEP;
			walk_index <= '0;
		end else begin
			state <= next_state;
			walk_index <= next_walk_index;
		end
	end

	always_comb begin
		next_state = state;
		next_walk_index = walk_index;
		o_ready = 1'b0;
		o_rdata = ram_rdata.data;
		o_bus_request = 1'b0;
		ram_write = 1'b0;
		ram_address = i_req.address[`CACHE_INDEX_BITS+1:2];
		ram_wdata = '{data: i_bus_rdata, tag: req_tag, valid: 1'b1};

		case (state)
			// Reset sweep, also run for an invalidate.
			ST_SWEEP: begin
				ram_address = walk_index[`CACHE_INDEX_BITS-1:0];
				ram_wdata = '{data: '0, tag: `CACHE_INVALID_TAG, valid: 1'b0};
				if (!walk_index[`CACHE_INDEX_BITS]) begin
					ram_write = 1'b1;
					next_walk_index = walk_index + 1'b1;
				end else begin
					o_ready = i_request && i_req.flush;
					next_state = ST_IDLE;
				end
			end

			ST_IDLE: begin
				if (i_request) begin
					if (i_req.flush) begin
						next_walk_index = '0;
						next_state = ST_SWEEP;
					end else begin
						next_state = ST_LOOKUP;
					end
				end
			end

			ST_LOOKUP: begin
				if (ram_rdata.valid && ram_rdata.tag == req_tag) begin
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end else begin
					next_state = ST_FILL_WAIT;
				end
			end

			// Word goes to the CPU and into the RAM together.
			ST_FILL_WAIT: begin
				o_bus_request = 1'b1;
				o_rdata = i_bus_rdata;
				if (i_bus_ready) begin
					ram_write = 1'b1;
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end
			end

			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
# Builds and runs the cache subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
	--top-module tb_cache_subsystem -o sim_cache
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "No result line in the log"
	exit 1
fi
exit 0

/* tb_cache_subsystem.sv */
`default_nettype none
`timescale 1ns/1ps

`include "cache_config.svh"

module tb_cache_subsystem;
	import cache_pkg::*;

	localparam int WAIT_LIMIT = 200;

	logic clock;
	logic reset;
	logic data_request;
	cpu_req_t data_req;
	logic data_ready;
	logic [31:0] data_rdata;
	logic fetch_request;
	cpu_req_t fetch_req;
	logic fetch_ready;
	logic [31:0] fetch_rdata;
	logic bus_request;
	bus_req_t bus_req;
	logic bus_ready;
	logic [31:0] bus_rdata;

	logic [31:0] mem [256];
	logic [31:0] shadow [256];
	logic mem_busy;
	logic [1:0] wait_left;
	logic [15:0] lfsr = 16'd97;
	logic [7:0] post_reset_cycles;
	logic expect_hit;
	int fail_count;
	int test_count;
	int test_start_fails;

	tb_clock_gen u_clock_gen (
		.o_clock(clock),
		.o_reset(reset)
	);

	cache_subsystem dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_data_request(data_request),
		.i_data_req(data_req),
		.o_data_ready(data_ready),
		.o_data_rdata(data_rdata),
		.i_fetch_request(fetch_request),
		.i_fetch_req(fetch_req),
		.o_fetch_ready(fetch_ready),
		.o_fetch_rdata(fetch_rdata),
		.o_bus_request(bus_request),
		.o_bus_req(bus_req),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	// Galois LFSR, taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] value);
		logic out_bit;
		out_bit = value[0];
		value = value >> 1;
		if (out_bit) begin
			value = value ^ 16'hB400;
		end
		return value;
	endfunction

	// Initial memory word, a mix of every address bit.
	function automatic logic [31:0] fill_word(input logic [7:0] index);
		return {8'hA5, index, ~index, index ^ 8'h3C};
	endfunction

	// ============================================================
	// Memory model
	// ============================================================
	always @(posedge clock) begin
		bus_ready <= 1'b0;
		if (reset || bus_ready) begin
			mem_busy <= 1'b0;
		end else if (bus_request) begin
			if (!mem_busy) begin
				mem_busy <= 1'b1;
				wait_left[0] <= lfsr[0];
				lfsr = lfsr_next(lfsr);
				wait_left[1] <= lfsr[0];
				lfsr = lfsr_next(lfsr);
			end else if (wait_left == 2'd0) begin
				bus_ready <= 1'b1;
				bus_rdata <= mem[bus_req.address[9:2]];
				if (bus_req.rw) begin
					mem[bus_req.address[9:2]] <= bus_req.wdata;
				end
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

	// Shadow follows every completed CPU write.
	always @(posedge clock) begin
		if (data_ready && data_req.rw && !data_req.flush) begin
			shadow[data_req.address[9:2]] <= data_req.wdata;
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			post_reset_cycles <= '0;
		end else if (post_reset_cycles != 8'hFF) begin
			post_reset_cycles <= post_reset_cycles + 8'd1;
		end
	end

	// ============================================================
	// Checks
	// ============================================================
	sweep_quiet: assert property (@(posedge clock)
		(!reset && post_reset_cycles <= `CACHE_ENTRIES) |->
		(!bus_request && !data_ready && !fetch_ready))
	else begin
		$display("Fail sweep o_bus_request %h o_data_ready %h o_fetch_ready %h expected 0",
			bus_request, data_ready, fetch_ready);
		fail_count++;
	end

	data_read_value: assert property (@(posedge clock)
		(data_ready && !data_req.rw && !data_req.flush) |->
		(data_rdata == shadow[data_req.address[9:2]]))
	else begin
		$display("Fail o_data_rdata addr %h got %h expected %h", data_req.address,
			data_rdata, shadow[data_req.address[9:2]]);
		fail_count++;
	end

	fetch_read_value: assert property (@(posedge clock)
		(fetch_ready && !fetch_req.flush) |->
		(fetch_rdata == shadow[fetch_req.address[9:2]]))
	else begin
		$display("Fail o_fetch_rdata addr %h got %h expected %h", fetch_req.address,
			fetch_rdata, shadow[fetch_req.address[9:2]]);
		fail_count++;
	end

	hit_no_bus: assert property (@(posedge clock) expect_hit |-> !bus_request)
	else begin
		$display("Fail o_bus_request during hit addr %h got %h expected %h",
			data_req.address, bus_request, 1'b0);
		fail_count++;
	end

	// One data port access, held until ready.
	task automatic data_access(input logic rw, input logic flush, input logic cacheable,
		input logic [31:0] address, input logic [31:0] wdata, input logic hit);
		int count;
		logic got;
		count = 0;
		got = 1'b0;
		@(posedge clock);
		data_request <= 1'b1;
		data_req <= '{rw: rw, flush: flush, cacheable: cacheable, address: address,
			wdata: wdata};
		expect_hit <= hit;
		while (!got && count < WAIT_LIMIT) begin
			@(posedge clock);
			got = data_ready;
			count++;
		end
		data_request <= 1'b0;
		expect_hit <= 1'b0;
		if (!got) begin
			$display("Data access to %h got no ready before the timeout", address);
			fail_count++;
		end
	endtask

	task automatic fetch_access(input logic flush, input logic [31:0] address);
		int count;
		logic got;
		count = 0;
		got = 1'b0;
		@(posedge clock);
		fetch_request <= 1'b1;
		fetch_req <= '{rw: 1'b0, flush: flush, cacheable: 1'b1, address: address,
			wdata: '0};
		while (!got && count < WAIT_LIMIT) begin
			@(posedge clock);
			got = fetch_ready;
			count++;
		end
		fetch_request <= 1'b0;
		if (!got) begin
			$display("Fetch from %h got no ready before the timeout", address);
			fail_count++;
		end
	endtask

	task automatic compare_memory();
		for (int i = 0; i < 256; i++) begin
			assert (mem[i] == shadow[i])
			else begin
				$display("Fail mem addr %h got %h expected %h", i * 4, mem[i], shadow[i]);
				fail_count++;
			end
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (fail_count == test_start_fails) begin
			$display("Test %0d %s: ok", test_count, name);
		end else begin
			$display("Test %0d %s: %0d errors", test_count, name,
				fail_count - test_start_fails);
		end
		test_start_fails = fail_count;
	endtask

	// Watchdog for the whole run.
	initial begin
		#200000;
		$display("Simulation ran past its time limit");
		$display("TEST FAILED");
		$finish;
	end

	// ============================================================
	// Stimulus
	// ============================================================
	initial begin
		data_request = 1'b0;
		data_req = '0;
		fetch_request = 1'b0;
		fetch_req = '0;
		bus_ready = 1'b0;
		bus_rdata = '0;
		mem_busy = 1'b0;
		wait_left = '0;
		expect_hit = 1'b0;
		fail_count = 0;
		test_count = 0;
		test_start_fails = 0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i[7:0]);
			shadow[i] = fill_word(i[7:0]);
		end

		// Both requests wait through reset and the sweep.
		fork
			data_access(1'b0, 1'b0, 1'b1, 32'h000, '0, 1'b0);
			fetch_access(1'b0, 32'h300);
		join

		// Cold reads fill every entry.
		for (int i = 1; i < 16; i++) begin
			data_access(1'b0, 1'b0, 1'b1, i * 4, '0, 1'b0);
		end
		end_test("reset sweep and cold reads");

		for (int i = 0; i < 8; i++) begin
			data_access(1'b1, 1'b0, 1'b1, i * 4, 32'h1111_0000 + i, 1'b0);
		end
		for (int i = 0; i < 8; i++) begin
			data_access(1'b0, 1'b0, 1'b1, i * 4, '0, 1'b1);
			data_access(1'b0, 1'b0, 1'b1, i * 4, '0, 1'b1);
		end
		end_test("write then read");

		// 0x080 and 0x0C0 share index 0.
		data_access(1'b1, 1'b0, 1'b1, 32'h080, 32'hAAAA_0080, 1'b0);
		data_access(1'b1, 1'b0, 1'b1, 32'h0C0, 32'hBBBB_00C0, 1'b0);
		data_access(1'b0, 1'b0, 1'b0, 32'h080, '0, 1'b0);
		end_test("eviction");

		for (int i = 1; i < 5; i++) begin
			data_access(1'b1, 1'b0, 1'b1, i * 4, 32'h2222_0000 + i, 1'b0);
		end
		data_access(1'b0, 1'b1, 1'b1, '0, '0, 1'b0);
		compare_memory();
		end_test("flush");

		fork
			begin
				for (int i = 0; i < 12; i++) begin
					fetch_access(1'b0, 32'h200 + i * 4);
				end
			end
			begin
				for (int i = 0; i < 12; i++) begin
					data_access(1'b0, 1'b0, 1'b1, 32'h100 + i * 4, '0, 1'b0);
				end
			end
		join
		end_test("concurrent fetch");

		fetch_access(1'b0, 32'h240);
		data_access(1'b1, 1'b0, 1'b0, 32'h240, 32'h0DDC_0DE0, 1'b0);
		fetch_access(1'b1, '0);
		fetch_access(1'b0, 32'h240);
		end_test("code update");

		$display("%0d tests run, %0d errors", test_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_reset
);

	// 8 ns period.
	initial begin
		o_clock = 1'b0;
		forever #4 o_clock = ~o_clock;
	end

	// Reset held for 8 rising edges.
	initial begin
		o_reset = 1'b1;
		repeat (8) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
cache_pkg.sv
cache_bram.sv
data_cache.sv
instruction_cache.sv
bus_arbiter.sv
cache_subsystem.sv
tb_clock_gen.sv
tb_cache_subsystem.sv
